// File: verilog/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define FETCH_ADDR_WIDTH 32
`define FETCH_DATA_WIDTH 32

// --------------------------------------------------
// Cache geometry
// --------------------------------------------------
// Byte bits inside one instruction word
`define BYTE_OFFSET_WIDTH 2
// 4 words per line, refill burst length field is 3
`define ICACHE_WORD_SEL_WIDTH 2
// 8 sets
`define ICACHE_INDEX_WIDTH 3

// Top address byte of the cached region
`define CACHEABLE_REGION 8'hA0

`endif

// File: verilog/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    // One instruction word
    typedef logic [`FETCH_DATA_WIDTH-1:0] word_t;

    // Address bits above index, word select and byte offset
    typedef logic [`FETCH_ADDR_WIDTH - `ICACHE_INDEX_WIDTH
                   - `ICACHE_WORD_SEL_WIDTH - `BYTE_OFFSET_WIDTH - 1:0] tag_t;

    // Set number
    typedef logic [`ICACHE_INDEX_WIDTH-1:0] set_index_t;

    // Word position inside a line
    typedef logic [`ICACHE_WORD_SEL_WIDTH-1:0] word_sel_t;

    // Whole cache line, word 0 in the low bits
    typedef word_t [(1 << `ICACHE_WORD_SEL_WIDTH)-1:0] line_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESP,
        BYPASS
    } cache_state_t;

endpackage

// File: verilog/icache_line_store.sv
`include "fetch_settings.svh"

module icache_line_store (
    input  logic                  clock,
    input  logic                  clear,

    // Tag install at the start of a refill
    input  logic                  install,
    input  fetch_pkg::set_index_t install_index,
    input  fetch_pkg::tag_t       install_tag,

    // One refill beat
    input  logic                  fill,
    input  fetch_pkg::set_index_t fill_index,
    input  fetch_pkg::word_sel_t  fill_word,
    input  fetch_pkg::word_t      fill_data,

    // Lookup port
    input  fetch_pkg::set_index_t lookup_index,
    input  fetch_pkg::word_sel_t  lookup_word,
    output logic                  lookup_valid,
    output fetch_pkg::tag_t       lookup_tag,
    output fetch_pkg::word_t      lookup_data
);

    localparam int NUM_SETS = 1 << `ICACHE_INDEX_WIDTH;

    logic [NUM_SETS-1:0] valid_bits;
    fetch_pkg::tag_t     tag_array  [NUM_SETS];
    fetch_pkg::line_t    data_array [NUM_SETS];

    // --------------------------------------------------
    // Valid bits
    // --------------------------------------------------
    // Clear wins over a same-cycle install
    always_ff @(posedge clock) begin
        if (clear) begin
            valid_bits <= '0;
        end else if (install) begin
            valid_bits[install_index] <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Tag and data arrays
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (install) begin
            tag_array[install_index] <= install_tag;
        end
    end

    // One word per accepted refill beat
    always_ff @(posedge clock) begin
        if (fill) begin
            data_array[fill_index][fill_word] <= fill_data;
        end
    end

    // Asynchronous read of the selected set
    assign lookup_valid = valid_bits[lookup_index];
    assign lookup_tag   = tag_array[lookup_index];
    assign lookup_data  = data_array[lookup_index][lookup_word];

    // Tag install and beat writes come from different controller states
    assert property (@(posedge clock) !(install && fill))
        else $error("line store: install and fill in the same cycle");

endmodule

// File: verilog/icache_ctrl.sv
`include "fetch_settings.svh"

module icache_ctrl (
    input  logic                          clock,
    input  logic                          reset,

    // Fetch side, fetch unit is master
    input  logic                          ifu_arvalid,
    output logic                          ifu_arready,
    input  logic [`FETCH_ADDR_WIDTH-1:0]  ifu_araddr,
    output logic                          ifu_rvalid,
    input  logic                          ifu_rready,
    output fetch_pkg::word_t              ifu_rdata,
    output logic                          ifu_rlast,

    // Memory side, controller is master
    output logic                          mem_arvalid,
    input  logic                          mem_arready,
    output logic [`FETCH_ADDR_WIDTH-1:0]  mem_araddr,
    output logic [7:0]                    mem_arlen,
    input  logic                          mem_rvalid,
    output logic                          mem_rready,
    input  fetch_pkg::word_t              mem_rdata,
    input  logic                          mem_rlast,

    // Line store
    output logic                          install,
    output fetch_pkg::set_index_t         install_index,
    output fetch_pkg::tag_t               install_tag,
    output logic                          fill,
    output fetch_pkg::set_index_t         fill_index,
    output fetch_pkg::word_sel_t          fill_word,
    output fetch_pkg::word_t              fill_data,
    output fetch_pkg::set_index_t         lookup_index,
    output fetch_pkg::word_sel_t          lookup_word,
    input  logic                          lookup_valid,
    input  fetch_pkg::tag_t               lookup_tag,
    input  fetch_pkg::word_t              lookup_data,

    // Event pulses for the counters
    output logic                          lookup_hit,
    output logic                          lookup_miss,
    output logic                          bypass_start
);

    // Address field positions
    localparam int WORD_LSB  = `BYTE_OFFSET_WIDTH;
    localparam int INDEX_LSB = WORD_LSB + `ICACHE_WORD_SEL_WIDTH;
    localparam int TAG_LSB   = INDEX_LSB + `ICACHE_INDEX_WIDTH;

    localparam logic [7:0] REFILL_LEN = 8'((1 << `ICACHE_WORD_SEL_WIDTH) - 1);
    localparam fetch_pkg::word_sel_t LAST_BEAT = '1;

    fetch_pkg::cache_state_t      state;
    logic [`FETCH_ADDR_WIDTH-1:0] req_addr;
    logic                         ar_pending;
    fetch_pkg::word_sel_t         beat_count;
    logic                         req_accept;
    logic                         req_cacheable;
    logic                         tag_hit;
    logic                         last_beat;

    assign ifu_arready   = (state == fetch_pkg::IDLE);
    assign req_accept    = ifu_arvalid && ifu_arready;
    assign req_cacheable = (ifu_araddr[`FETCH_ADDR_WIDTH-1 -: 8] == `CACHEABLE_REGION);

    // Held request address
    always_ff @(posedge clock) begin
        if (req_accept) begin
            req_addr <= ifu_araddr;
        end
    end

    assign lookup_index = req_addr[INDEX_LSB +: `ICACHE_INDEX_WIDTH];
    assign lookup_word  = req_addr[WORD_LSB +: `ICACHE_WORD_SEL_WIDTH];
    assign tag_hit      = lookup_valid
                          && (lookup_tag == req_addr[TAG_LSB +: $bits(fetch_pkg::tag_t)]);
    assign last_beat    = (beat_count == LAST_BEAT);

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= fetch_pkg::IDLE;
            ar_pending <= 1'b0;
            beat_count <= '0;
        end else begin
            case (state)
                fetch_pkg::IDLE: begin
                    if (req_accept) begin
                        state      <= req_cacheable ? fetch_pkg::LOOKUP : fetch_pkg::BYPASS;
                        ar_pending <= !req_cacheable;
                    end
                end
                fetch_pkg::LOOKUP: begin
                    if (tag_hit) begin
                        state <= fetch_pkg::RESP;
                    end else begin
                        state      <= fetch_pkg::REFILL;
                        ar_pending <= 1'b1;
                        beat_count <= '0;
                    end
                end
                fetch_pkg::REFILL: begin
                    if (mem_arready) begin
                        ar_pending <= 1'b0;
                    end
                    if (mem_rvalid) begin
                        beat_count <= beat_count + fetch_pkg::word_sel_t'(1);
                        if (last_beat) begin
                            state <= fetch_pkg::RESP;
                        end
                    end
                end
                fetch_pkg::RESP: begin
                    if (ifu_rready) begin
                        state <= fetch_pkg::IDLE;
                    end
                end
                fetch_pkg::BYPASS: begin
                    if (mem_arready) begin
                        ar_pending <= 1'b0;
                    end
                    if (mem_rvalid && ifu_rready) begin
                        state <= fetch_pkg::IDLE;
                    end
                end
                default: state <= fetch_pkg::IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Memory read channels
    // --------------------------------------------------
    assign mem_arvalid = ar_pending;
    assign mem_arlen   = (state == fetch_pkg::REFILL) ? REFILL_LEN : 8'd0;
    // Refill starts at word 0 of the line
    assign mem_araddr  = (state == fetch_pkg::REFILL)
                         ? {req_addr[`FETCH_ADDR_WIDTH-1:INDEX_LSB], {INDEX_LSB{1'b0}}}
                         : req_addr;

    always_comb begin
        case (state)
            fetch_pkg::REFILL: mem_rready = 1'b1;
            fetch_pkg::BYPASS: mem_rready = ifu_rready;
            default:           mem_rready = 1'b0;
        endcase
    end

    // Fetch response, bypass beats pass straight through
    assign ifu_rvalid = (state == fetch_pkg::RESP) || ((state == fetch_pkg::BYPASS) && mem_rvalid);
    assign ifu_rdata  = (state == fetch_pkg::BYPASS) ? mem_rdata : lookup_data;
    assign ifu_rlast  = (state == fetch_pkg::BYPASS) ? mem_rlast : (state == fetch_pkg::RESP);

    // Line store writes
    assign install       = (state == fetch_pkg::LOOKUP) && !tag_hit;
    assign install_index = lookup_index;
    assign install_tag   = req_addr[TAG_LSB +: $bits(fetch_pkg::tag_t)];
    assign fill          = (state == fetch_pkg::REFILL) && mem_rvalid;
    assign fill_index    = lookup_index;
    assign fill_word     = beat_count;
    assign fill_data     = mem_rdata;

    // Counter events
    assign lookup_hit   = (state == fetch_pkg::LOOKUP) && tag_hit;
    assign lookup_miss  = (state == fetch_pkg::LOOKUP) && !tag_hit;
    assign bypass_start = req_accept && !req_cacheable;

    // Memory closes the burst on the fourth beat and no other
    assert property (@(posedge clock) disable iff (reset)
        (state == fetch_pkg::REFILL && mem_rvalid) |-> (mem_rlast == last_beat))
        else $error("icache_ctrl: rlast out of place in refill burst");

    // Held response while the fetch unit stalls
    assert property (@(posedge clock) disable iff (reset)
        (ifu_rvalid && !ifu_rready) |=> (ifu_rvalid && $stable(ifu_rdata) && $stable(ifu_rlast)))
        else $error("icache_ctrl: fetch response changed before rready");

endmodule

// File: verilog/icache_perf_counters.sv
module icache_perf_counters (
    input  logic        clock,
    input  logic        reset,

    // One-cycle event pulses
    input  logic        lookup_hit,
    input  logic        lookup_miss,
    input  logic        bypass_start,

    output logic [31:0] hit_count,
    output logic [31:0] miss_count,
    output logic [31:0] bypass_count
);

    // --------------------------------------------------
    // Saturating increment
    // --------------------------------------------------
    function automatic logic [31:0] bump(
        input logic [31:0] count,
        input logic        event_seen
    );
        if (event_seen && (count != '1)) begin
            return count + 32'd1;
        end
        return count;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hit_count    <= '0;
            miss_count   <= '0;
            bypass_count <= '0;
        end else begin
            hit_count    <= bump(hit_count, lookup_hit);
            miss_count   <= bump(miss_count, lookup_miss);
            bypass_count <= bump(bypass_count, bypass_start);
        end
    end

    // A lookup resolves one way only
    assert property (@(posedge clock) disable iff (reset)
        !(lookup_hit && lookup_miss))
        else $error("perf counters: hit and miss in the same cycle");

endmodule

// File: verilog/fetch_mem_top.sv
`include "fetch_settings.svh"

module fetch_mem_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          clear,

    // Fetch side
    input  logic                          ifu_arvalid,
    output logic                          ifu_arready,
    input  logic [`FETCH_ADDR_WIDTH-1:0]  ifu_araddr,
    output logic                          ifu_rvalid,
    input  logic                          ifu_rready,
    output fetch_pkg::word_t              ifu_rdata,
    output logic                          ifu_rlast,

    // Memory side
    output logic                          mem_arvalid,
    input  logic                          mem_arready,
    output logic [`FETCH_ADDR_WIDTH-1:0]  mem_araddr,
    output logic [7:0]                    mem_arlen,
    input  logic                          mem_rvalid,
    output logic                          mem_rready,
    input  fetch_pkg::word_t              mem_rdata,
    input  logic                          mem_rlast,

    // Performance counters
    output logic [31:0]                   hit_count,
    output logic [31:0]                   miss_count,
    output logic [31:0]                   bypass_count
);

    // --------------------------------------------------
    // Controller to line store
    // --------------------------------------------------
    logic                  install;
    fetch_pkg::set_index_t install_index;
    fetch_pkg::tag_t       install_tag;
    logic                  fill;
    fetch_pkg::set_index_t fill_index;
    fetch_pkg::word_sel_t  fill_word;
    fetch_pkg::word_t      fill_data;
    fetch_pkg::set_index_t lookup_index;
    fetch_pkg::word_sel_t  lookup_word;
    logic                  lookup_valid;
    fetch_pkg::tag_t       lookup_tag;
    fetch_pkg::word_t      lookup_data;

    // Controller to counters
    logic lookup_hit;
    logic lookup_miss;
    logic bypass_start;

    icache_ctrl i_icache_ctrl (
        .clock, .reset,
        .ifu_arvalid, .ifu_arready, .ifu_araddr,
        .ifu_rvalid, .ifu_rready, .ifu_rdata, .ifu_rlast,
        .mem_arvalid, .mem_arready, .mem_araddr, .mem_arlen,
        .mem_rvalid, .mem_rready, .mem_rdata, .mem_rlast,
        .install, .install_index, .install_tag,
        .fill, .fill_index, .fill_word, .fill_data,
        .lookup_index, .lookup_word, .lookup_valid, .lookup_tag, .lookup_data,
        .lookup_hit, .lookup_miss, .bypass_start
    );

    // Reset also empties the cache
    icache_line_store i_icache_line_store (
        .clock,
        .clear         (clear || reset),
        .install, .install_index, .install_tag,
        .fill, .fill_index, .fill_word, .fill_data,
        .lookup_index, .lookup_word, .lookup_valid, .lookup_tag, .lookup_data
    );

    icache_perf_counters i_icache_perf_counters (
        .clock, .reset,
        .lookup_hit, .lookup_miss, .bypass_start,
        .hit_count, .miss_count, .bypass_count
    );

endmodule

// File: testbench/axi_read_mem_model.sv
`include "fetch_settings.svh"

module axi_read_mem_model (
    input  logic                         clock,
    input  int                           epoch,
    input  logic                         mem_arvalid,
    output logic                         mem_arready,
    input  logic [`FETCH_ADDR_WIDTH-1:0] mem_araddr,
    input  logic [7:0]                   mem_arlen,
    output logic                         mem_rvalid,
    input  logic                         mem_rready,
    output fetch_pkg::word_t             mem_rdata,
    output logic                         mem_rlast
);

    logic [15:0]                  lfsr;
    logic                         in_burst;
    logic                         beat_taken;
    logic [`FETCH_ADDR_WIDTH-1:0] burst_addr;
    logic [7:0]                   burst_len;
    logic [7:0]                   beat;

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic next_bit();
        logic feedback;
        feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr     = {lfsr[14:0], feedback};
        return feedback;
    endfunction

    // Memory content of one word address in one epoch
    function automatic fetch_pkg::word_t content(input logic [31:0] addr, input int era);
        return {addr[15:0], addr[31:16]} ^ (32'(era) * 32'h9E37_79B9) ^ 32'h1357_2468;
    endfunction

    initial begin
        lfsr        = 16'd6;
        in_burst    = 1'b0;
        beat_taken  = 1'b0;
        beat        = '0;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_rlast   = 1'b0;
        forever begin
            // Drive on the falling edge, rvalid held until taken
            @(negedge clock);
            if (!in_burst) begin
                mem_rvalid  = 1'b0;
                mem_rlast   = 1'b0;
                mem_arready = next_bit() | next_bit();
            end else begin
                mem_arready = 1'b0;
                if (!mem_rvalid || beat_taken) begin
                    mem_rvalid = next_bit() | next_bit();
                    mem_rdata  = content(burst_addr + 32'(beat) * 4, epoch);
                    mem_rlast  = (beat == burst_len);
                end
            end
            beat_taken = 1'b0;
            @(posedge clock);
            if (!in_burst && mem_arvalid && mem_arready) begin
                in_burst   = 1'b1;
                burst_addr = mem_araddr;
                burst_len  = mem_arlen;
                beat       = '0;
            end else if (in_burst && mem_rvalid && mem_rready) begin
                beat_taken = 1'b1;
                in_burst   = (beat != burst_len);
                beat       = beat + 8'd1;
            end
        end
    end

endmodule

// File: testbench/fetch_mem_tb.sv
`include "fetch_settings.svh"

module fetch_mem_tb;

    localparam int KIND_HIT         = 0;
    localparam int KIND_MISS        = 1;
    localparam int KIND_BYPASS      = 2;
    localparam int ACCEPT_TIMEOUT   = 20;
    localparam int RESPONSE_TIMEOUT = 300;
    localparam int NUM_SETS         = 1 << `ICACHE_INDEX_WIDTH;
    localparam int LINE_WORDS       = 1 << `ICACHE_WORD_SEL_WIDTH;
    localparam int INDEX_LSB        = `BYTE_OFFSET_WIDTH + `ICACHE_WORD_SEL_WIDTH;
    localparam int TAG_LSB          = INDEX_LSB + `ICACHE_INDEX_WIDTH;
    localparam logic [31:0] CACHED_BASE = {`CACHEABLE_REGION, 24'h0};

    logic             clock, reset, clear;
    logic             ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready, ifu_rlast;
    logic [31:0]      ifu_araddr, mem_araddr;
    logic             mem_arvalid, mem_arready, mem_rvalid, mem_rready, mem_rlast;
    logic [7:0]       mem_arlen;
    fetch_pkg::word_t ifu_rdata, mem_rdata;
    logic [31:0]      hit_count, miss_count, bypass_count;
    int               epoch;

    // Reference cache model
    logic             model_valid [NUM_SETS];
    fetch_pkg::tag_t  model_tag   [NUM_SETS];
    int               model_epoch [NUM_SETS];
    int               predicted_kind, model_hits, model_misses, model_bypasses;

    // Outstanding fetch and monitor state
    fetch_pkg::word_t expected_q[$];
    int               kind_q[$];
    logic [31:0]      addr_q[$];
    int               edge_count, accept_edge, ar_count, responses;
    logic             valid_seen;
    logic [15:0]      stall_lfsr, addr_lfsr;

    fetch_mem_top i_fetch_mem_top (.*);
    axi_read_mem_model i_axi_read_mem_model (.*);

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] draw_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            addr_lfsr = lfsr_step(addr_lfsr);
            value     = {value[30:0], addr_lfsr[0]};
        end
        return value;
    endfunction

    // Two tags per set so that lines get evicted
    // One fetch in four bypasses
    function automatic logic [31:0] random_address();
        logic [31:0] bits;
        bits = draw_bits(8);
        if (bits[7:6] == 2'b00) begin
            return {8'h3C, 16'h0, bits[5:0], 2'b00};
        end
        return CACHED_BASE | {bits[5], 5'b0, bits[4:0], 2'b00};
    endfunction

    function automatic fetch_pkg::word_t memory_word(input logic [31:0] addr, input int era);
        return {addr[15:0], addr[31:16]} ^ (32'(era) * 32'h9E37_79B9) ^ 32'h1357_2468;
    endfunction

    // Expected word of one fetch and the model tag update on a miss
    function automatic fetch_pkg::word_t reference_fetch(input logic [31:0] addr);
        int              index;
        fetch_pkg::tag_t tag;
        index = int'(addr[INDEX_LSB +: `ICACHE_INDEX_WIDTH]);
        tag   = addr[31:TAG_LSB];
        if (addr[31:24] != `CACHEABLE_REGION) begin
            predicted_kind = KIND_BYPASS;
            return memory_word(addr, epoch);
        end
        if (model_valid[index] && model_tag[index] == tag) begin
            predicted_kind = KIND_HIT;
        end else begin
            predicted_kind     = KIND_MISS;
            model_valid[index] = 1'b1;
            model_tag[index]   = tag;
            model_epoch[index] = epoch;
        end
        return memory_word(addr, model_epoch[index]);
    endfunction

    task automatic report_error(input string message);
        $display("%s", message);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            report_error($sformatf("MISMATCH at time %0t: %s = %h, expected %h",
                                   $time, name, actual, expected));
        end
    endtask

    task automatic fetch(input logic [31:0] addr);
        int   target;
        int   waited;
        logic accepted;
        @(negedge clock);
        target      = responses + 1;
        ifu_arvalid = 1'b1;
        ifu_araddr  = addr;
        waited      = 0;
        accepted    = 1'b0;
        while (!accepted) begin
            @(posedge clock);
            accepted = ifu_arready;
            waited++;
            if (!accepted && waited >= ACCEPT_TIMEOUT) begin
                report_error("fetch request was not accepted in time");
            end
        end
        @(negedge clock);
        ifu_arvalid = 1'b0;
        waited      = 0;
        while (responses < target) begin
            if (waited >= RESPONSE_TIMEOUT) begin
                report_error("no fetch response arrived within the timeout");
            end
            @(negedge clock);
            waited++;
        end
    endtask

    task automatic clear_cache();
        @(negedge clock);
        clear = 1'b1;
        for (int i = 0; i < NUM_SETS; i++) begin
            model_valid[i] = 1'b0;
        end
        @(negedge clock);
        clear = 1'b0;
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Fetch-side back-pressure with ready three cycles in four
    always @(negedge clock) begin
        stall_lfsr = lfsr_step(stall_lfsr);
        ifu_rready = stall_lfsr[0];
        stall_lfsr = lfsr_step(stall_lfsr);
        ifu_rready = ifu_rready | stall_lfsr[0];
    end

    // --------------------------------------------------
    // Checker sampling at the rising edge
    // --------------------------------------------------
    always @(posedge clock) begin
        if (!reset) begin
            // Requests are taken only while nothing is outstanding
            compare("ifu_arready", ifu_arready, kind_q.size() == 0);
            if (ifu_arvalid && ifu_arready) begin
                expected_q.push_back(reference_fetch(ifu_araddr));
                kind_q.push_back(predicted_kind);
                addr_q.push_back(ifu_araddr);
                accept_edge    = edge_count;
                ar_count       = 0;
                valid_seen     = 1'b0;
                model_hits     += (predicted_kind == KIND_HIT);
                model_misses   += (predicted_kind == KIND_MISS);
                model_bypasses += (predicted_kind == KIND_BYPASS);
            end
            if (mem_arvalid && mem_arready) begin
                if (kind_q.size() == 0) begin
                    report_error("memory read address with no fetch outstanding");
                end else if (kind_q[0] == KIND_HIT) begin
                    report_error("memory read issued for a cache hit");
                end else if (kind_q[0] == KIND_MISS) begin
                    compare("mem_araddr", mem_araddr, addr_q[0] & ~32'(LINE_WORDS * 4 - 1));
                    compare("mem_arlen", mem_arlen, LINE_WORDS - 1);
                end else begin
                    compare("mem_araddr", mem_araddr, addr_q[0]);
                    compare("mem_arlen", mem_arlen, 0);
                end
                ar_count++;
            end
            // Refill takes every beat and bypass beats wait for the fetch side
            if (mem_rvalid && kind_q.size() != 0) begin
                compare("mem_rready", mem_rready,
                        kind_q[0] == KIND_MISS ? 1'b1 : ifu_rready);
            end
            if (ifu_rvalid && kind_q.size() == 0) begin
                report_error("fetch response valid with no request outstanding");
            end else if (ifu_rvalid && !valid_seen) begin
                valid_seen = 1'b1;
                if (kind_q[0] == KIND_HIT) begin
                    compare("hit latency in edges", edge_count - accept_edge, 2);
                end
            end
            if (ifu_rvalid && ifu_rready) begin
                compare("ifu_rdata", ifu_rdata, expected_q.pop_front());
                compare("ifu_rlast", ifu_rlast, 1);
                compare("memory reads per fetch", ar_count,
                        kind_q.pop_front() == KIND_HIT ? 0 : 1);
                addr_q.delete(0);
                responses++;
            end
        end
        edge_count++;
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        reset          = 1'b1;
        clear          = 1'b0;
        ifu_arvalid    = 1'b0;
        ifu_araddr     = '0;
        ifu_rready     = 1'b0;
        epoch          = 0;
        stall_lfsr     = 16'd6;
        addr_lfsr      = 16'd6;
        edge_count     = 0;
        accept_edge    = 0;
        ar_count       = 0;
        responses      = 0;
        valid_seen     = 1'b0;
        model_hits     = 0;
        model_misses   = 0;
        model_bypasses = 0;
        for (int i = 0; i < NUM_SETS; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
            model_epoch[i] = 0;
        end
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Misses at every word position and hits across those lines
        for (int w = 0; w < LINE_WORDS; w++) begin
            fetch(CACHED_BASE + w * 16 + w * 4);
        end
        for (int line = 0; line < 4; line++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                fetch(CACHED_BASE + line * 16 + w * 4);
            end
        end

        // Bypass reads including neighbours of the cached region
        fetch(32'h1000_0000);
        fetch(32'hA100_0040);
        fetch(32'h9FFF_FFFC);

        // Stale lines until cleared
        epoch = 1;
        for (int w = 0; w < LINE_WORDS; w++) begin
            fetch(CACHED_BASE + w * 20);
        end
        fetch(32'h1000_0000);
        clear_cache();
        for (int w = 0; w < LINE_WORDS; w++) begin
            fetch(CACHED_BASE + w * 20);
        end

        // Random mix under stalls on both sides
        for (int i = 0; i < 80; i++) begin
            if (i == 40) begin
                epoch = 2;
            end
            if (i == 60) begin
                clear_cache();
            end
            fetch(random_address());
        end

        @(negedge clock);
        compare("hit_count", hit_count, model_hits);
        compare("miss_count", miss_count, model_misses);
        compare("bypass_count", bypass_count, model_bypasses);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/icache_line_store.sv
verilog/icache_ctrl.sv
verilog/icache_perf_counters.sv
verilog/fetch_mem_top.sv
testbench/axi_read_mem_model.sv
testbench/fetch_mem_tb.sv

// File: Bender.yml
package:
  name: fetch_mem

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_pkg.sv
      - verilog/icache_line_store.sv
      - verilog/icache_ctrl.sv
      - verilog/icache_perf_counters.sv
      - verilog/fetch_mem_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/axi_read_mem_model.sv
      - testbench/fetch_mem_tb.sv
